/* hdl/dcache_wb_pkg.sv */
`default_nettype none

package dcache_wb_pkg;

    ////////////////////////////////////////
    // Line geometry
    ////////////////////////////////////////
    localparam int ADDR_W      = 32;
    localparam int LINE_BYTES  = 32;
    localparam int LINE_BITS   = LINE_BYTES * 8;          // 256
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);      // Byte offset inside a line

    ////////////////////////////////////////
    // AXI write side
    ////////////////////////////////////////
    localparam int AXI_WIDTH     = 64;
    localparam int BEATS         = LINE_BITS / AXI_WIDTH; // 4 beats per line
    localparam int BEAT_W        = $clog2(BEATS);
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // Write-back queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = QPTR_W + 1;              // Holds 0..QUEUE_DEPTH

    // Clean victim counter width
    localparam int CNT_W = 16;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [LINE_BITS-1:0] line_t;    // Beat i at bits [64*i +: 64]
    typedef logic [AXI_WIDTH-1:0] axi_word_t;

    typedef enum logic [1:0] {
        IDLE,   // Waiting for a queued line
        ADDR,   // AW beat offered
        DATA,   // W beats in flight
        RESP    // Waiting on B
    } wb_state_t;

endpackage

`default_nettype wire

/* hdl/wb_line_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One dirty line with its aligned address, valid/ready handshake
interface wb_line_if import dcache_wb_pkg::*; ();

    logic  valid;
    logic  ready;
    addr_t addr;
    line_t data;

    modport source (
        output valid,
        output addr,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  addr,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

/* hdl/wb_evict_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_evict_ctrl import dcache_wb_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    // Victim offered by replacement logic
    input  logic             evict_valid,
    input  logic             evict_dirty,
    input  addr_t            evict_addr,
    input  line_t            evict_data,
    output logic             evict_ready,
    output logic [CNT_W-1:0] clean_drop_cnt,
    // Dirty lines toward the queue
    wb_line_if.source        out
);

    logic  line_vld;    // Output register occupied
    addr_t line_addr;
    line_t line_data;
    logic  clean_seen;  // Clean victim taken last edge
    logic  take;
    logic  drain;

    assign drain = line_vld && out.ready;
    // Free now, or freed by the queue in this same cycle
    assign evict_ready = !line_vld || out.ready;
    assign take        = evict_valid && evict_ready;

    ////////////////////////////////////////
    // One-line output register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            line_vld <= 1'b0;
        end else if (take && evict_dirty) begin
            line_vld <= 1'b1;   // Refill, even while draining
        end else if (drain) begin
            line_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take && evict_dirty) begin
            line_addr <= {evict_addr[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            line_data <= evict_data;
        end
    end

    assign out.valid = line_vld;
    assign out.addr  = line_addr;
    assign out.data  = line_data;

    ////////////////////////////////////////
    // Clean victim count
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            clean_seen     <= 1'b0;
            clean_drop_cnt <= '0;
        end else begin
            clean_seen <= take && !evict_dirty;
            if (clean_seen) clean_drop_cnt <= clean_drop_cnt + 1'b1;  // One edge later
        end
    end

endmodule

`default_nettype wire

/* hdl/wb_line_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_line_queue import dcache_wb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    wb_line_if.sink   in,
    wb_line_if.source out
);

    addr_t addr_mem [QUEUE_DEPTH];
    line_t data_mem [QUEUE_DEPTH];

    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W-1:0] rd_ptr_nxt;
    logic [QCNT_W-1:0] count;

    addr_t head_addr;   // Registered copy of entry at rd_ptr
    line_t head_data;
    logic  push;
    logic  pop;

    assign in.ready = (count != QCNT_W'(QUEUE_DEPTH));
    assign push     = in.valid && in.ready;
    assign pop      = out.valid && out.ready;
    assign rd_ptr_nxt = pop ? rd_ptr + 1'b1 : rd_ptr;

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            rd_ptr <= rd_ptr_nxt;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= in.addr;
            data_mem[wr_ptr] <= in.data;
        end
    end

    ////////////////////////////////////////
    // Head read, bypass when queue drains empty
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (push && (wr_ptr == rd_ptr_nxt)) begin
            head_addr <= in.addr;
            head_data <= in.data;
        end else begin
            head_addr <= addr_mem[rd_ptr_nxt];
            head_data <= data_mem[rd_ptr_nxt];
        end
    end

    assign out.valid = (count != '0);
    assign out.addr  = head_addr;
    assign out.data  = head_data;

endmodule

`default_nettype wire

/* hdl/wb_axi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_axi_master import dcache_wb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    wb_line_if.sink    in,
    // AW channel
    output addr_t      AWADDR,
    output logic       AWVALID,
    input  logic       AWREADY,
    // W channel
    output axi_word_t  WDATA,
    output logic       WLAST,
    output logic       WVALID,
    input  logic       WREADY,
    // B channel
    input  logic [1:0] BRESP,
    input  logic       BVALID,
    output logic       BREADY,
    // Status
    output logic       wb_done,
    output logic       wb_err
);

    wb_state_t state;
    wb_state_t state_nxt;

    addr_t             addr_q;
    line_t             line_q;      // Current beat in the low slice
    logic [BEAT_W-1:0] beat_cnt;

    logic take;
    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic last_beat;

    assign in.ready  = (state == IDLE);
    assign take      = in.valid && in.ready;
    assign aw_fire   = AWVALID && AWREADY;
    assign w_fire    = WVALID && WREADY;
    assign b_fire    = BVALID && BREADY;
    assign last_beat = (beat_cnt == BEAT_W'(BEATS - 1));

    ////////////////////////////////////////
    // State machine
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (take)                state_nxt = ADDR;
            ADDR: if (aw_fire)             state_nxt = DATA;
            DATA: if (w_fire && last_beat) state_nxt = RESP;
            RESP: if (b_fire)              state_nxt = IDLE;
            default:                       state_nxt = IDLE;
        endcase
    end

    // Line latch and beat shifter
    always_ff @(posedge clk) begin
        if (take) begin
            addr_q <= in.addr;
            line_q <= in.data;
        end else if (w_fire) begin
            line_q <= line_q >> AXI_WIDTH;  // Next slice down
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (aw_fire) begin
            beat_cnt <= '0;
        end else if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Completion and sticky error
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_done <= 1'b0;
            wb_err  <= 1'b0;
        end else begin
            wb_done <= b_fire;
            if (b_fire && (BRESP != AXI_RESP_OKAY)) wb_err <= 1'b1;
        end
    end

    // Bus outputs follow the state
    assign AWADDR  = addr_q;
    assign AWVALID = (state == ADDR);
    assign WDATA   = line_q[AXI_WIDTH-1:0];
    assign WVALID  = (state == DATA);
    assign WLAST   = (state == DATA) && last_beat;
    assign BREADY  = (state == RESP);

endmodule

`default_nettype wire

/* hdl/dcache_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_wb_top import dcache_wb_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    // Victim port from the cache
    input  logic             evict_valid,
    input  logic             evict_dirty,
    input  addr_t            evict_addr,
    input  line_t            evict_data,
    output logic             evict_ready,
    output logic [CNT_W-1:0] clean_drop_cnt,
    // AXI write master
    output addr_t            AWADDR,
    output logic             AWVALID,
    input  logic             AWREADY,
    output axi_word_t        WDATA,
    output logic             WLAST,
    output logic             WVALID,
    input  logic             WREADY,
    input  logic [1:0]       BRESP,
    input  logic             BVALID,
    output logic             BREADY,
    output logic             wb_done,
    output logic             wb_err
);

    wb_line_if evict_if ();
    wb_line_if queue_if ();

    wb_evict_ctrl wb_evict_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .evict_valid    (evict_valid),
        .evict_dirty    (evict_dirty),
        .evict_addr     (evict_addr),
        .evict_data     (evict_data),
        .evict_ready    (evict_ready),
        .clean_drop_cnt (clean_drop_cnt),
        .out            (evict_if)
    );

    wb_line_queue wb_line_queue_i (
        .clk (clk),
        .rst (rst),
        .in  (evict_if),
        .out (queue_if)
    );

    wb_axi_master wb_axi_master_i (
        .clk     (clk),
        .rst     (rst),
        .in      (queue_if),
        .AWADDR  (AWADDR),
        .AWVALID (AWVALID),
        .AWREADY (AWREADY),
        .WDATA   (WDATA),
        .WLAST   (WLAST),
        .WVALID  (WVALID),
        .WREADY  (WREADY),
        .BRESP   (BRESP),
        .BVALID  (BVALID),
        .BREADY  (BREADY),
        .wb_done (wb_done),
        .wb_err  (wb_err)
    );

endmodule

`default_nettype wire

/* verif/axi_wr_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

// AXI write slave for the testbench, fixed 4-beat INCR bursts
module axi_wr_slave_model import dcache_wb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // Stall and response control from the testbench
    input  logic       aw_stall,
    input  logic       w_stall,
    input  logic [1:0] resp_code,
    // AXI write channels
    input  addr_t      AWADDR,
    input  logic       AWVALID,
    output logic       AWREADY,
    input  axi_word_t  WDATA,
    input  logic       WLAST,
    input  logic       WVALID,
    output logic       WREADY,
    output logic [1:0] BRESP,
    output logic       BVALID,
    input  logic       BREADY,
    // Captured burst
    output addr_t      cap_addr,
    output line_t      cap_line,
    output logic [2:0] beat_idx,    // Beats taken since the last AW
    output logic       line_rcvd    // One cycle, burst complete in cap_*
);

    assign AWREADY = !aw_stall;
    assign WREADY  = !w_stall;

    ////////////////////////////////////////
    // Beat capture and response
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            BVALID    <= 1'b0;
            BRESP     <= 2'b00;
            beat_idx  <= '0;
            line_rcvd <= 1'b0;
        end else begin
            line_rcvd <= 1'b0;
            if (AWVALID && AWREADY) begin
                cap_addr <= AWADDR;
                beat_idx <= '0;
            end
            if (WVALID && WREADY) begin
                cap_line[AXI_WIDTH*beat_idx +: AXI_WIDTH] <= WDATA;
                beat_idx <= beat_idx + 1'b1;
                if (WLAST) begin
                    BVALID    <= 1'b1;      // Answer right after the last beat
                    BRESP     <= resp_code;
                    line_rcvd <= 1'b1;
                end
            end
            if (BVALID && BREADY) begin
                BVALID <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_dcache_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_wb import dcache_wb_pkg::*; ();

    localparam int SEND_LIMIT  = 500;
    localparam int DRAIN_LIMIT = 4000;

    logic             clk;
    logic             rst;
    logic             evict_valid;
    logic             evict_dirty;
    addr_t            evict_addr;
    line_t            evict_data;
    logic             evict_ready;
    logic [CNT_W-1:0] clean_drop_cnt;
    addr_t            AWADDR;
    logic             AWVALID;
    logic             AWREADY;
    axi_word_t        WDATA;
    logic             WLAST;
    logic             WVALID;
    logic             WREADY;
    logic [1:0]       BRESP;
    logic             BVALID;
    logic             BREADY;
    logic             wb_done;
    logic             wb_err;

    logic       aw_stall;
    logic       w_stall;
    logic       aw_roll = 1'b0;
    logic       w_roll = 1'b0;
    logic [1:0] resp_code;
    addr_t      cap_addr;
    line_t      cap_line;
    logic [2:0] beat_idx;
    logic       line_rcvd;

    integer seed = 51644;
    int     stall_pct = 0;
    int     errors = 0;
    int     timeouts = 0;

    // Reference model and scoreboard counters
    addr_t ref_addr [$];
    line_t ref_line [$];
    addr_t exp_a;
    line_t exp_l;
    int    dirty_sent = 0;
    int    clean_sent = 0;
    int    lines_rcvd = 0;
    int    b_cnt = 0;
    int    done_cnt = 0;
    logic  ready_low_seen = 1'b0;

    // Pipelined expectations, updated on the clock
    logic             clean_q = 1'b0;
    logic [CNT_W-1:0] exp_clean = '0;
    logic             err_exp = 1'b0;
    logic             aw_hold = 1'b0;
    addr_t            aw_prev;
    logic             w_hold = 1'b0;
    axi_word_t        w_prev;
    logic             wlast_prev;

    dcache_wb_top dcache_wb_top_i (
        .clk            (clk),
        .rst            (rst),
        .evict_valid    (evict_valid),
        .evict_dirty    (evict_dirty),
        .evict_addr     (evict_addr),
        .evict_data     (evict_data),
        .evict_ready    (evict_ready),
        .clean_drop_cnt (clean_drop_cnt),
        .AWADDR         (AWADDR),
        .AWVALID        (AWVALID),
        .AWREADY        (AWREADY),
        .WDATA          (WDATA),
        .WLAST          (WLAST),
        .WVALID         (WVALID),
        .WREADY         (WREADY),
        .BRESP          (BRESP),
        .BVALID         (BVALID),
        .BREADY         (BREADY),
        .wb_done        (wb_done),
        .wb_err         (wb_err)
    );

    axi_wr_slave_model axi_wr_slave_model_i (
        .clk       (clk),
        .rst       (rst),
        .aw_stall  (aw_stall),
        .w_stall   (w_stall),
        .resp_code (resp_code),
        .AWADDR    (AWADDR),
        .AWVALID   (AWVALID),
        .AWREADY   (AWREADY),
        .WDATA     (WDATA),
        .WLAST     (WLAST),
        .WVALID    (WVALID),
        .WREADY    (WREADY),
        .BRESP     (BRESP),
        .BVALID    (BVALID),
        .BREADY    (BREADY),
        .cap_addr  (cap_addr),
        .cap_line  (cap_line),
        .beat_idx  (beat_idx),
        .line_rcvd (line_rcvd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////
    task automatic report_mismatch(input string name, input line_t exp, input line_t act);
        $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_event(input string msg);
        $display("Check failed at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_run();
        $display("Errors: %0d  Timeouts: %0d  Lines written: %0d  Clean dropped: %0d",
                 errors, timeouts, lines_rcvd, clean_sent);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        timeouts++;
        finish_run();
    endtask

    // Random ready stalls on the AW and W channels, rolled between edges
    always @(negedge clk) begin
        aw_roll = ($unsigned($random(seed)) % 100) < stall_pct;
        w_roll  = ($unsigned($random(seed)) % 100) < stall_pct;
    end

    always @(posedge clk) begin
        aw_stall <= aw_roll;
        w_stall  <= w_roll;
    end

    ////////////////////////////////////////
    // Monitor and checks
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (!rst) begin
            if (evict_valid && evict_ready) begin
                if (evict_dirty) begin
                    ref_addr.push_back(evict_addr & ~addr_t'(LINE_BYTES - 1));
                    ref_line.push_back(evict_data);
                    dirty_sent++;
                end else begin
                    clean_sent++;
                end
            end
            if (evict_valid && !evict_ready) ready_low_seen = 1'b1;

            // Clean count lags the handshake by one edge
            clean_q <= evict_valid && evict_ready && !evict_dirty;
            if (clean_q) exp_clean <= exp_clean + 1'b1;
            assert (clean_drop_cnt == exp_clean)
                else report_mismatch("clean_drop_cnt", exp_clean, clean_drop_cnt);

            if (aw_hold) begin
                assert (AWVALID) else report_event("AWVALID dropped before its transfer");
                assert (AWADDR == aw_prev) else report_mismatch("AWADDR", aw_prev, AWADDR);
            end
            if (w_hold) begin
                assert (WVALID) else report_event("WVALID dropped before its transfer");
                assert (WDATA == w_prev) else report_mismatch("WDATA", w_prev, WDATA);
                assert (WLAST == wlast_prev) else report_mismatch("WLAST", wlast_prev, WLAST);
            end
            aw_hold    <= AWVALID && !AWREADY;
            aw_prev    <= AWADDR;
            w_hold     <= WVALID && !WREADY;
            w_prev     <= WDATA;
            wlast_prev <= WLAST;

            if (WVALID && WREADY) begin
                assert (beat_idx < BEATS)
                    else report_event("a W beat arrived outside a four-beat burst");
                assert (WLAST == (beat_idx == BEATS - 1))
                    else report_mismatch("WLAST", beat_idx == BEATS - 1, WLAST);
            end

            if (line_rcvd) begin
                if (ref_addr.size() == 0) begin
                    report_event("an AXI burst arrived with no dirty victim pending");
                end else begin
                    exp_a = ref_addr.pop_front();
                    exp_l = ref_line.pop_front();
                    assert (cap_addr == exp_a) else report_mismatch("AWADDR", exp_a, cap_addr);
                    assert (cap_line == exp_l) else report_mismatch("WDATA line", exp_l, cap_line);
                end
                lines_rcvd++;
            end

            // wb_done must follow exactly one new B transfer
            if (wb_done) begin
                assert (b_cnt == done_cnt + 1)
                    else report_event("wb_done pulsed without a matching B transfer");
                done_cnt++;
            end
            if (BVALID && BREADY) begin
                b_cnt++;
                if (BRESP != 2'b00) err_exp <= 1'b1;    // Sticky
            end
            assert (wb_err == err_exp) else report_mismatch("wb_err", err_exp, wb_err);
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic send_victim(input logic dirty, input addr_t addr, input line_t data);
        int waited;
        begin
            evict_valid <= 1'b1;
            evict_dirty <= dirty;
            evict_addr  <= addr;
            evict_data  <= data;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!evict_ready && waited < SEND_LIMIT);
            if (!evict_ready) report_timeout("a victim was never accepted, evict_ready stayed low");
        end
    endtask

    task automatic send_random(input logic dirty);
        addr_t a;
        line_t d;
        begin
            a = $random(seed);
            for (int k = 0; k < LINE_BITS / 32; k++) begin
                d[32*k +: 32] = $random(seed);
            end
            send_victim(dirty, a, d);
        end
    endtask

    task automatic wait_drain();
        int waited;
        begin
            evict_valid <= 1'b0;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while ((done_cnt != dirty_sent || ref_addr.size() != 0) && waited < DRAIN_LIMIT);
            if (done_cnt != dirty_sent) report_timeout("the write-back path did not drain");
            repeat (2) @(posedge clk);  // Let the clean count settle
        end
    endtask

    task automatic check_reset_state();
        assert (!AWVALID) else report_mismatch("AWVALID", 0, AWVALID);
        assert (!WVALID) else report_mismatch("WVALID", 0, WVALID);
        assert (!BREADY) else report_mismatch("BREADY", 0, BREADY);
        assert (!wb_done) else report_mismatch("wb_done", 0, wb_done);
        assert (!wb_err) else report_mismatch("wb_err", 0, wb_err);
        assert (clean_drop_cnt == '0) else report_mismatch("clean_drop_cnt", 0, clean_drop_cnt);
        assert (evict_ready) else report_mismatch("evict_ready", 1, evict_ready);
    endtask

    initial begin
        rst         = 1'b1;
        evict_valid = 1'b0;
        evict_dirty = 1'b0;
        evict_addr  = '0;
        evict_data  = '0;
        aw_stall    = 1'b0;
        w_stall     = 1'b0;
        resp_code   = 2'b00;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_reset_state();

        // Dirty lines on an open bus
        repeat (3) send_random(1'b1);
        wait_drain();

        // Clean victims mixed in
        send_random(1'b0);
        send_random(1'b1);
        send_random(1'b0);
        send_random(1'b0);
        send_random(1'b1);
        wait_drain();
        assert (clean_drop_cnt == CNT_W'(clean_sent))
            else report_mismatch("clean_drop_cnt", clean_sent, clean_drop_cnt);

        // Back-pressure, long burst of dirty victims
        stall_pct = 60;
        repeat (10) send_random(1'b1);
        wait_drain();
        assert (ready_low_seen) else report_event("evict_ready never fell under back-pressure");
        stall_pct = 0;

        // Slave error, then clean responses
        resp_code <= 2'b10;
        send_random(1'b1);
        wait_drain();
        resp_code <= 2'b00;
        repeat (2) send_random(1'b1);
        wait_drain();
        assert (wb_err) else report_mismatch("wb_err", 1, wb_err);

        assert (ref_addr.size() == 0) else report_event("dirty lines were never written");
        assert (lines_rcvd == dirty_sent) else report_mismatch("lines", dirty_sent, lines_rcvd);
        assert (done_cnt == dirty_sent) else report_mismatch("wb_done count", dirty_sent, done_cnt);
        finish_run();
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/dcache_wb_pkg.sv
hdl/wb_line_if.sv
hdl/wb_evict_ctrl.sv
hdl/wb_line_queue.sv
hdl/wb_axi_master.sv
hdl/dcache_wb_top.sv
verif/axi_wr_slave_model.sv
verif/tb_dcache_wb.sv
